// File: dv/denise_tb.sv
// Testbench for the playfield video path
// Clock, reset, LCG, register-write tasks and reference rules
// Output assertions, watchdog and test report
module denise_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import denise_reg_pkg::*;
  import denise_pix_pkg::*;

  localparam int LINE_LEN   = 64;
  localparam int CLK_PERIOD = 100;
  localparam int RST_CYC    = 8;
  localparam int IDLE_CYC   = 16;
  localparam int DRAIN_CYC  = 40;
  // Six writes plus the longest idle gap
  localparam int GROUP_MAX  = 22;
  localparam int N_SINGLE   = 8;
  localparam int N_BPU3     = 6;
  localparam int N_DUAL     = 6;
  localparam int N_SCROLL   = 6;
  localparam int N_WINDOW   = 6;
  localparam int N_GROUPS   = N_SINGLE + N_BPU3 + 2 * N_DUAL + 2 * N_SCROLL + N_WINDOW;
  localparam int N_WRITES   = NUM_COLORS + 16;
  localparam int N_DRAINS   = 8;
  localparam int WORK_CYC   = RST_CYC + IDLE_CYC + N_WRITES + N_GROUPS * GROUP_MAX
                              + N_DRAINS * DRAIN_CYC;
  localparam int MARGIN_CYC = 200;
  localparam int EXP_DEPTH  = 4096;

  // Colour write waiting to reach the table
  typedef struct packed {
    int         t;
    logic [4:0] sel;
    rgb_t       rgb;
  } clut_wr_t;

  logic        clk;
  logic        rst;
  logic        reg_wr;
  rga_t        reg_addr;
  reg_word_t   reg_data;
  logic [3:0]  red;
  logic [3:0]  green;
  logic [3:0]  blue;
  logic        blank_n;
  logic        sol;

  int          edge_num;
  int          err_cnt;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  int          sol_seen;
  logic        started;
  logic [31:0] lcg_state;
  ctrl_t       t_ctrl;
  rgb_t        shadow [NUM_COLORS];
  plane_bits_t exp_planes [EXP_DEPTH];
  clut_wr_t    pend_q [$];
  rgb_t        want_rgb;
  logic        want_blank_n;
  logic        want_sol;

  denise_top #(
    .LINE_LEN (LINE_LEN)
  ) dut (
    .clk      (clk),
    .rst      (rst),
    .reg_wr   (reg_wr),
    .reg_addr (reg_addr),
    .reg_data (reg_data),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .blank_n  (blank_n),
    .sol      (sol)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Edge 0 is the first rising edge with rst low
  always @(posedge clk) begin
    started <= 1'b1;
    if (!rst) begin
      edge_num <= edge_num + 1;
    end
    if (sol === 1'b1) begin
      sol_seen++;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Plane bits to colour index per BPU, DBLPF and PF2PRI
  function automatic clut_idx_t ref_index(input plane_bits_t p, input logic in_win);
    plane_bits_t vis;
    logic [2:0]  pf1;
    logic [2:0]  pf2;
    for (int i = 0; i < NUM_PLANES; i++) begin
      vis[i] = p[i] && (i < int'(t_ctrl.bpu)) && in_win;
    end
    if (!t_ctrl.dblpf) begin
      return vis;
    end
    pf1 = {vis[4], vis[2], vis[0]};
    pf2 = {vis[5], vis[3], vis[1]};
    if (pf1 == 3'd0 && pf2 == 3'd0) begin
      return '0;
    end else if (pf2 == 3'd0 || (pf1 != 3'd0 && !t_ctrl.pf2pri)) begin
      return clut_idx_t'(pf1);
    end
    // PF2 palette starts at colour 8
    return clut_idx_t'(8 + int'(pf2));
  endfunction

  // Half-brite halves each nibble
  function automatic rgb_t ref_color(input clut_idx_t idx);
    rgb_t c;
    c = shadow[idx[4:0]];
    if (idx[5]) begin
      c = {1'b0, c[11:9], 1'b0, c[7:5], 1'b0, c[3:1]};
    end
    return c;
  endfunction

  // Expected outputs after edge m, position m modulo the line
  always @(posedge clk) begin : expect_proc
    int          m;
    int          pos;
    logic        in_win;
    plane_bits_t p;
    rgb_t        rgb;
    if (rst) begin
      want_rgb     <= '0;
      want_blank_n <= 1'b0;
      want_sol     <= 1'b0;
    end else begin
      m = edge_num;
      // Table read at m-1 sees writes up to m-3
      while (pend_q.size() > 0 && pend_q[0].t <= m - 3) begin
        shadow[pend_q[0].sel] = pend_q[0].rgb;
        void'(pend_q.pop_front());
      end
      pos    = m % LINE_LEN;
      in_win = (pos >= int'(t_ctrl.diw_start)) && (pos < int'(t_ctrl.diw_stop));
      p      = (m < EXP_DEPTH) ? exp_planes[m] : '0;
      rgb    = ref_color(ref_index(p, in_win));
      if (pos >= int'(HBLANK_FIRST) && pos <= int'(HBLANK_LAST)) begin
        want_rgb     <= '0;
        want_blank_n <= 1'b0;
      end else begin
        want_rgb     <= rgb;
        want_blank_n <= 1'b1;
      end
      want_sol <= (pos == 0);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Output checks on the falling edge
  ////////////////////////////////////////////////////////////////////

  chk_red: assert property (@(negedge clk) disable iff (!started) red == want_rgb[11:8])
    else begin
      err_cnt++;
      $display("Mismatch red: got %h expected %h at %0t", red, want_rgb[11:8], $time);
    end
  chk_green: assert property (@(negedge clk) disable iff (!started) green == want_rgb[7:4])
    else begin
      err_cnt++;
      $display("Mismatch green: got %h expected %h at %0t", green, want_rgb[7:4], $time);
    end
  chk_blue: assert property (@(negedge clk) disable iff (!started) blue == want_rgb[3:0])
    else begin
      err_cnt++;
      $display("Mismatch blue: got %h expected %h at %0t", blue, want_rgb[3:0], $time);
    end
  chk_blank: assert property (@(negedge clk) disable iff (!started) blank_n == want_blank_n)
    else begin
      err_cnt++;
      $display("Mismatch blank_n: got %h expected %h at %0t", blank_n, want_blank_n, $time);
    end
  chk_sol: assert property (@(negedge clk) disable iff (!started) sol == want_sol)
    else begin
      err_cnt++;
      $display("Mismatch sol: got %h expected %h at %0t", sol, want_sol, $time);
    end

  ////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all entered on a falling edge
  ////////////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One write, sampled at the next rising edge
  task automatic write_reg(input rga_t addr, input reg_word_t data);
    clut_wr_t cw;
    int       off;
    reg_wr   = 1'b1;
    reg_addr = addr;
    reg_data = data;
    off      = int'(addr) - int'(ADDR_COLOR00);
    case (addr)
      ADDR_DIWSTRT: t_ctrl.diw_start = data[8:0];
      ADDR_DIWSTOP: t_ctrl.diw_stop = data[8:0];
      ADDR_BPLCON0: begin
        t_ctrl.bpu   = data[14:12];
        t_ctrl.dblpf = data[10];
      end
      ADDR_BPLCON1: begin
        t_ctrl.pf1h = data[3:0];
        t_ctrl.pf2h = data[7:4];
      end
      ADDR_BPLCON2: t_ctrl.pf2pri = data[6];
      default: begin
        if (off >= 0 && off < NUM_COLORS) begin
          cw.t   = edge_num;
          cw.sel = 5'(off);
          cw.rgb = data[11:0];
          pend_q.push_back(cw);
        end
      end
    endcase
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic write_random_colors();
    logic [31:0] r;
    for (int i = 0; i < NUM_COLORS; i++) begin
      r = next_rand();
      write_reg(rga_t'(int'(ADDR_COLOR00) + i), {4'h0, r[27:16]});
    end
  endtask

  // Planes 6..2 first, BPL1DAT last starts the load
  task automatic load_group(input logic [NUM_PLANES-1:0][15:0] w);
    int t;
    int s;
    int c;
    for (int i = NUM_PLANES - 1; i >= 1; i--) begin
      write_reg(rga_t'(int'(ADDR_BPL1DAT) + i), w[i]);
    end
    t = edge_num;
    write_reg(ADDR_BPL1DAT, w[0]);
    // Bit 15-k reaches the output after edge t+4+s+k
    for (int k = 0; k < 16; k++) begin
      for (int i = 0; i < NUM_PLANES; i++) begin
        s = (i % 2 == 0) ? int'(t_ctrl.pf1h) : int'(t_ctrl.pf2h);
        c = t + 4 + s + k;
        if (c < EXP_DEPTH) begin
          exp_planes[c][i] = w[i][15-k];
        end
      end
    end
  endtask

  task automatic stream_groups(input int n, input int idle, input logic dense);
    logic [NUM_PLANES-1:0][15:0] w;
    logic [31:0]                 r;
    for (int g = 0; g < n; g++) begin
      for (int i = 0; i < NUM_PLANES; i++) begin
        r    = next_rand();
        w[i] = dense ? (r[23:8] | 16'h0810) : r[23:8];
      end
      load_group(w);
      wait_cycles(idle);
    end
  endtask

  task automatic set_random_scroll();
    logic [31:0] r;
    r = next_rand();
    write_reg(ADDR_BPLCON1, {8'h00, r[15:12], r[19:16]});
  endtask

  task automatic end_test(input string name);
    int errs;
    errs     = err_cnt - err_mark;
    err_mark = err_cnt;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", tests_run, name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int want_sol_cnt;
    clk          = 1'b0;
    rst          = 1'b1;
    reg_wr       = 1'b0;
    reg_addr     = '0;
    reg_data     = '0;
    edge_num     = 0;
    err_cnt      = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    sol_seen     = 0;
    started      = 1'b0;
    lcg_state    = 32'h3372;
    // Reset state, whole line open
    t_ctrl          = '0;
    t_ctrl.diw_stop = 9'd511;
    for (int i = 0; i < NUM_COLORS; i++) begin
      shadow[i] = '0;
    end
    for (int i = 0; i < EXP_DEPTH; i++) begin
      exp_planes[i] = '0;
    end
    wait_cycles(RST_CYC);
    rst = 1'b0;
    wait_cycles(IDLE_CYC);
    end_test("reset_and_blank");

    // Six planes, half-brite on plane 6
    write_reg(ADDR_BPLCON0, 16'h6000);
    write_random_colors();
    stream_groups(N_SINGLE, 10, 1'b0);
    wait_cycles(DRAIN_CYC);
    end_test("single_ehb");

    // Planes 4..6 loaded but masked
    write_reg(ADDR_BPLCON0, 16'h3000);
    stream_groups(N_BPU3, 10, 1'b1);
    wait_cycles(DRAIN_CYC);
    end_test("bpu_three");

    write_reg(ADDR_BPLCON0, 16'h6400);
    write_reg(ADDR_BPLCON2, 16'h0000);
    stream_groups(N_DUAL, 10, 1'b0);
    wait_cycles(DRAIN_CYC);
    write_reg(ADDR_BPLCON2, 16'h0040);
    stream_groups(N_DUAL, 10, 1'b0);
    wait_cycles(DRAIN_CYC);
    end_test("dual_playfield");

    // Gap of 16 keeps pending loads clear of the next words
    write_reg(ADDR_BPLCON0, 16'h6000);
    set_random_scroll();
    stream_groups(N_SCROLL, IDLE_CYC, 1'b0);
    wait_cycles(DRAIN_CYC);
    set_random_scroll();
    stream_groups(N_SCROLL, IDLE_CYC, 1'b0);
    wait_cycles(DRAIN_CYC);
    end_test("scroll_delay");

    write_reg(ADDR_BPLCON1, 16'h0000);
    write_reg(ADDR_DIWSTRT, 16'd24);
    write_reg(ADDR_DIWSTOP, 16'd40);
    stream_groups(N_WINDOW, 10, 1'b1);
    wait_cycles(DRAIN_CYC);
    // Pulses counted up to the output of edge edge_num-2
    want_sol_cnt = (edge_num - 2) / LINE_LEN + 1;
    assert (sol_seen == want_sol_cnt)
      else begin
        err_cnt++;
        $display("Mismatch sol pulse count: got %h expected %h", sol_seen, want_sol_cnt);
      end
    write_reg(ADDR_DIWSTOP, 16'h01FF);
    end_test("window_and_sol");

    wait_cycles(4);
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Run length plus margin, in clock periods
  initial begin : watchdog
    #((WORK_CYC + MARGIN_CYC) * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WORK_CYC + MARGIN_CYC);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
hw/denise_pix_pkg.sv
hw/denise_reg_pkg.sv
hw/reg_decode.sv
hw/beam_counter.sv
hw/playfield_shifter.sv
hw/playfield_priority.sv
hw/color_output.sv
hw/denise_top.sv
dv/denise_tb.sv

// File: hw/beam_counter.sv
// Free-running horizontal beam counter
// Display window, fixed blanking and start-of-line flags
// Delay line that keeps the flags in step with the pixel
module beam_counter #(
  parameter int LINE_LEN = 227
) (
  input  logic                  clk,
  input  logic                  rst,
  input  denise_reg_pkg::ctrl_t ctrl,
  output denise_pix_pkg::beam_t beam
);
  import denise_pix_pkg::*;

  // Flag stages inside this block
  localparam int DLY = 3;
  // Counter runs ahead by these stages plus the priority and table read
  localparam int LEAD = DLY + 2;
  localparam hpos_t POS_RST  = hpos_t'(LEAD % LINE_LEN);
  localparam hpos_t POS_LAST = hpos_t'(LINE_LEN - 1);

  hpos_t hpos;
  beam_t now;
  beam_t dly [DLY];

  // Position of the pixel that reaches the output LEAD edges later
  always_ff @(posedge clk) begin
    if (rst) begin
      hpos <= POS_RST;
    end else if (hpos == POS_LAST) begin
      hpos <= '0;
    end else begin
      hpos <= hpos + 1'b1;
    end
  end

  always_comb begin
    now.in_window = (hpos >= ctrl.diw_start) && (hpos < ctrl.diw_stop);
    // Unsigned range check, first to last inclusive
    now.blank = hpos_t'(hpos - HBLANK_FIRST) <= hpos_t'(HBLANK_LAST - HBLANK_FIRST);
    now.sol   = (hpos == '0);
  end

  // Reset state covers positions inside blanking
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DLY; i++) begin
        dly[i] <= BEAM_BLANK;
      end
    end else begin
      dly[0] <= now;
      for (int i = 1; i < DLY; i++) begin
        dly[i] <= dly[i-1];
      end
    end
  end

  assign beam = dly[DLY-1];

endmodule

// File: hw/color_output.sv
// 32-entry colour look-up table with CPU writes
// Extra-half-brite and blanking of the RGB output
module color_output (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clut_wr,
  input  logic [4:0]           clut_sel,
  input  denise_pix_pkg::rgb_t clut_data,
  input  denise_pix_pkg::pix_t pix,
  output logic [3:0]           red,
  output logic [3:0]           green,
  output logic [3:0]           blue,
  output logic                 blank_n,
  output logic                 sol
);
  import denise_reg_pkg::*;
  import denise_pix_pkg::*;

  // First pixel after reset is the start of a line
  localparam beam_t BEAM_LINE_START = '{in_window: 1'b0, blank: 1'b1, sol: 1'b1};

  rgb_t  clut [NUM_COLORS];
  rgb_t  rd_rgb;
  logic  rd_half;
  beam_t rd_beam;
  rgb_t  shown;
  rgb_t  out_rgb;

  // COLORxx registers
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_COLORS; i++) begin
        clut[i] <= '0;
      end
    end else if (clut_wr) begin
      clut[clut_sel] <= clut_data;
    end
  end

  // Table read stage
  always_ff @(posedge clk) begin
    rd_rgb  <= clut[pix.idx[4:0]];
    rd_half <= pix.idx[5];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_beam <= BEAM_LINE_START;
    end else begin
      rd_beam <= pix.beam;
    end
  end

  // Half-brite, each nibble shifted right by one
  assign shown = rd_half ? ((rd_rgb >> 1) & 12'h777) : rd_rgb;

  // Output register, black while blanked
  always_ff @(posedge clk) begin
    if (rst) begin
      out_rgb <= '0;
      blank_n <= 1'b0;
      sol     <= 1'b0;
    end else begin
      out_rgb <= rd_beam.blank ? '0 : shown;
      blank_n <= !rd_beam.blank;
      sol     <= rd_beam.sol;
    end
  end

  assign red   = out_rgb[11:8];
  assign green = out_rgb[7:4];
  assign blue  = out_rgb[3:0];

endmodule

// File: hw/denise_pix_pkg.sv
// Pixel side types of the playfield video path
// Beam position, plane bits, colour index and 12-bit RGB
// Horizontal blanking range and pipeline-stage structs
package denise_pix_pkg;

  // Horizontal beam position in low-res pixels
  typedef logic [8:0]  hpos_t;

  // One bit from each of the six bitplanes, plane 1 in bit 0
  typedef logic [5:0]  plane_bits_t;

  // Colour index, bit 5 flags extra-half-brite
  typedef logic [5:0]  clut_idx_t;

  // 4 bits each, red in 11..8, green in 7..4, blue in 3..0
  typedef logic [11:0] rgb_t;

  // Inclusive horizontal blanking range
  localparam hpos_t HBLANK_FIRST = 9'd0;
  localparam hpos_t HBLANK_LAST  = 9'd15;

  // Beam flags that travel alongside each pixel
  typedef struct packed {
    logic in_window;
    logic blank;
    logic sol;
  } beam_t;

  // Blanked position with no line start, used to prime the pipe
  localparam beam_t BEAM_BLANK = '{in_window: 1'b0, blank: 1'b1, sol: 1'b0};

  // Resolved pixel, index plus its beam flags
  typedef struct packed {
    clut_idx_t idx;
    beam_t     beam;
  } pix_t;

endpackage

// File: hw/denise_reg_pkg.sv
// Register side of the playfield video path
// Word address map, register bus types and sizes
// Decoded control struct shared by the pipeline stages
package denise_reg_pkg;

  // Word address, byte address divided by two
  typedef logic [7:0]  rga_t;
  typedef logic [15:0] reg_word_t;

  // Register map, given as byte addresses
  localparam rga_t ADDR_DIWSTRT = rga_t'(9'h08E >> 1);
  localparam rga_t ADDR_DIWSTOP = rga_t'(9'h090 >> 1);
  localparam rga_t ADDR_BPLCON0 = rga_t'(9'h100 >> 1);
  localparam rga_t ADDR_BPLCON1 = rga_t'(9'h102 >> 1);
  localparam rga_t ADDR_BPLCON2 = rga_t'(9'h104 >> 1);
  // BPL1DAT..BPL6DAT on consecutive words
  localparam rga_t ADDR_BPL1DAT = rga_t'(9'h110 >> 1);
  // COLOR00..COLOR31 on consecutive words
  localparam rga_t ADDR_COLOR00 = rga_t'(9'h180 >> 1);

  localparam int NUM_PLANES = 6;
  localparam int NUM_COLORS = 32;

  // BPU field of BPLCON0
  typedef logic [2:0] plane_cnt_t;
  // PFxH field of BPLCON1
  typedef logic [3:0] scroll_t;

  // Decoded control state
  typedef struct packed {
    plane_cnt_t            bpu;
    logic                  dblpf;
    scroll_t               pf1h;
    scroll_t               pf2h;
    logic                  pf2pri;
    denise_pix_pkg::hpos_t diw_start;
    denise_pix_pkg::hpos_t diw_stop;
  } ctrl_t;

endpackage

// File: hw/denise_top.sv
// Top level of the playfield video path
// Register decoder, beam counter, shifters, priority and colour output
module denise_top #(
  parameter int LINE_LEN = 227
) (
  input  logic                      clk,
  input  logic                      rst,
  // Register write port
  input  logic                      reg_wr,
  input  denise_reg_pkg::rga_t      reg_addr,
  input  denise_reg_pkg::reg_word_t reg_data,
  // Video out
  output logic [3:0]                red,
  output logic [3:0]                green,
  output logic [3:0]                blue,
  output logic                      blank_n,
  output logic                      sol
);
  import denise_reg_pkg::*;
  import denise_pix_pkg::*;

  ctrl_t       ctrl;
  logic        bpl_wr;
  logic [2:0]  bpl_sel;
  reg_word_t   bpl_data;
  logic        clut_wr;
  logic [4:0]  clut_sel;
  rgb_t        clut_data;
  plane_bits_t planes;
  beam_t       beam;
  pix_t        pix;

  //////////////////////////////////////////////////////////////////////
  // Register side
  //////////////////////////////////////////////////////////////////////

  reg_decode u_reg_decode (
    .clk       (clk),
    .rst       (rst),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_data  (reg_data),
    .ctrl      (ctrl),
    .bpl_wr    (bpl_wr),
    .bpl_sel   (bpl_sel),
    .bpl_data  (bpl_data),
    .clut_wr   (clut_wr),
    .clut_sel  (clut_sel),
    .clut_data (clut_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Pixel pipeline
  //////////////////////////////////////////////////////////////////////

  beam_counter #(
    .LINE_LEN (LINE_LEN)
  ) u_beam_counter (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl),
    .beam (beam)
  );

  playfield_shifter u_playfield_shifter (
    .clk      (clk),
    .rst      (rst),
    .ctrl     (ctrl),
    .bpl_wr   (bpl_wr),
    .bpl_sel  (bpl_sel),
    .bpl_data (bpl_data),
    .planes   (planes)
  );

  playfield_priority u_playfield_priority (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .planes (planes),
    .beam   (beam),
    .pix    (pix)
  );

  color_output u_color_output (
    .clk       (clk),
    .rst       (rst),
    .clut_wr   (clut_wr),
    .clut_sel  (clut_sel),
    .clut_data (clut_data),
    .pix       (pix),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .blank_n   (blank_n),
    .sol       (sol)
  );

endmodule

// File: hw/playfield_priority.sv
// Bitplane enable masking and window gating
// Single and dual playfield colour index selection
// Index register carrying the beam flags along
module playfield_priority (
  input  logic                        clk,
  input  logic                        rst,
  input  denise_reg_pkg::ctrl_t       ctrl,
  input  denise_pix_pkg::plane_bits_t planes,
  input  denise_pix_pkg::beam_t       beam,
  output denise_pix_pkg::pix_t        pix
);
  import denise_reg_pkg::*;
  import denise_pix_pkg::*;

  plane_bits_t plane_en;
  plane_bits_t vis;
  logic [2:0]  pf1_bits;
  logic [2:0]  pf2_bits;
  clut_idx_t   idx;

  // Planes at or above BPU are off
  always_comb begin
    for (int i = 0; i < NUM_PLANES; i++) begin
      plane_en[i] = (int'(ctrl.bpu) > i);
    end
  end

  // Outside the window everything reads as colour 0
  assign vis = planes & plane_en & {NUM_PLANES{beam.in_window}};

  // PF1 from planes 5/3/1, PF2 from planes 6/4/2
  assign pf1_bits = {vis[4], vis[2], vis[0]};
  assign pf2_bits = {vis[5], vis[3], vis[1]};

  //////////////////////////////////////////////////////////////////////
  // Playfield resolution
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!ctrl.dblpf) begin
      // Plane bits are the index, plane 6 gives half-brite
      idx = vis;
    end else if (pf2_bits == 3'b000) begin
      // PF2 transparent, also covers both transparent
      idx = {3'b000, pf1_bits};
    end else if ((pf1_bits == 3'b000) || ctrl.pf2pri) begin
      // PF2 colours sit at 8..15
      idx = {3'b001, pf2_bits};
    end else begin
      idx = {3'b000, pf1_bits};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pix <= '{idx: '0, beam: BEAM_BLANK};
    end else begin
      pix <= '{idx: idx, beam: beam};
    end
  end

endmodule

// File: hw/playfield_shifter.sv
// Bitplane data holding registers
// Per-playfield scroll delay counters
// Six pixel shift registers feeding the plane bits
module playfield_shifter (
  input  logic                        clk,
  input  logic                        rst,
  input  denise_reg_pkg::ctrl_t       ctrl,
  input  logic                        bpl_wr,
  input  logic [2:0]                  bpl_sel,
  input  denise_reg_pkg::reg_word_t   bpl_data,
  output denise_pix_pkg::plane_bits_t planes
);
  import denise_reg_pkg::*;

  reg_word_t bpldat [NUM_PLANES];
  reg_word_t shreg  [NUM_PLANES];
  scroll_t   dly_cnt [2];
  logic [1:0] dly_run;
  logic [1:0] load;
  scroll_t   pfh [2];
  logic      bpl1_wr;

  // Writing BPL1DAT arms the shifter load
  assign bpl1_wr = bpl_wr && (bpl_sel == 3'd0);

  // Index 0 is PF1 (odd planes), index 1 is PF2 (even planes)
  assign pfh[0] = ctrl.pf1h;
  assign pfh[1] = ctrl.pf2h;

  //////////////////////////////////////////////////////////////////////
  // BPLxDAT
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (bpl_wr) begin
      bpldat[bpl_sel] <= bpl_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scroll delay
  //////////////////////////////////////////////////////////////////////

  // Counts 0..15 after each BPL1DAT write, then idles
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_run <= 2'b00;
      for (int pf = 0; pf < 2; pf++) begin
        dly_cnt[pf] <= '0;
      end
    end else begin
      for (int pf = 0; pf < 2; pf++) begin
        if (bpl1_wr) begin
          dly_cnt[pf] <= '0;
          dly_run[pf] <= 1'b1;
        end else if (dly_run[pf]) begin
          if (dly_cnt[pf] == 4'hF) begin
            dly_run[pf] <= 1'b0;
          end else begin
            dly_cnt[pf] <= dly_cnt[pf] + 1'b1;
          end
        end
      end
    end
  end

  // Load when the count matches this playfield's delay
  always_comb begin
    for (int pf = 0; pf < 2; pf++) begin
      load[pf] = dly_run[pf] && (dly_cnt[pf] == pfh[pf]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shift registers
  //////////////////////////////////////////////////////////////////////

  // Zeros come in behind the word, MSB goes out first
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_PLANES; i++) begin
        shreg[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_PLANES; i++) begin
        if (load[i % 2]) begin
          shreg[i] <= bpldat[i];
        end else begin
          shreg[i] <= {shreg[i][14:0], 1'b0};
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_PLANES; i++) begin
      planes[i] = shreg[i][15];
    end
  end

endmodule

// File: hw/reg_decode.sv
// Register write decoder
// BPLCON0/1/2 and DIWSTRT/DIWSTOP control state
// Bitplane and colour write forwarding
module reg_decode (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      reg_wr,
  input  denise_reg_pkg::rga_t      reg_addr,
  input  denise_reg_pkg::reg_word_t reg_data,
  output denise_reg_pkg::ctrl_t     ctrl,
  output logic                      bpl_wr,
  output logic [2:0]                bpl_sel,
  output denise_reg_pkg::reg_word_t bpl_data,
  output logic                      clut_wr,
  output logic [4:0]                clut_sel,
  output denise_pix_pkg::rgb_t      clut_data
);
  import denise_reg_pkg::*;

  // Whole line open, single playfield, no planes
  localparam ctrl_t CTRL_RST = '{
    bpu:       3'd0,
    dblpf:     1'b0,
    pf1h:      4'd0,
    pf2h:      4'd0,
    pf2pri:    1'b0,
    diw_start: 9'd0,
    diw_stop:  9'd511
  };

  rga_t bpl_off;
  rga_t clut_off;
  logic bpl_hit;
  logic clut_hit;

  // Offsets into the BPLxDAT and COLORxx banks
  assign bpl_off  = reg_addr - ADDR_BPL1DAT;
  assign clut_off = reg_addr - ADDR_COLOR00;
  assign bpl_hit  = (reg_addr >= ADDR_BPL1DAT) && (int'(bpl_off) < NUM_PLANES);
  assign clut_hit = (reg_addr >= ADDR_COLOR00) && (int'(clut_off) < NUM_COLORS);

  // Plane words go straight to the holding registers
  assign bpl_wr   = reg_wr && bpl_hit;
  assign bpl_sel  = bpl_off[2:0];
  assign bpl_data = reg_data;

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl    <= CTRL_RST;
      clut_wr <= 1'b0;
    end else begin
      if (reg_wr) begin
        case (reg_addr)
          // Horizontal part only, vertical bits not kept
          ADDR_DIWSTRT: ctrl.diw_start <= reg_data[8:0];
          ADDR_DIWSTOP: ctrl.diw_stop  <= reg_data[8:0];
          // BPU and DBLPF, rest of BPLCON0 dropped
          ADDR_BPLCON0: begin
            ctrl.bpu   <= reg_data[14:12];
            ctrl.dblpf <= reg_data[10];
          end
          // PF1H low nibble, PF2H next nibble
          ADDR_BPLCON1: begin
            ctrl.pf1h <= reg_data[3:0];
            ctrl.pf2h <= reg_data[7:4];
          end
          ADDR_BPLCON2: ctrl.pf2pri <= reg_data[6];
          default: ;
        endcase
      end
      // Colour writes land in the table one edge later
      clut_wr <= reg_wr && clut_hit;
    end
  end

  always_ff @(posedge clk) begin
    clut_sel  <= clut_off[4:0];
    clut_data <= reg_data[11:0];
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module denise_tb -o denise_sim \
  && ./obj_dir/denise_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
